// ==== design/cpu_macros.svh ====
// Width, reset PC, register count and halt word macros for any datapath file that includes them
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width
`define CPU_WORD_W 32

// Register index width and register file depth
`define CPU_REG_W 5
`define CPU_REG_COUNT 32

// First fetch address after reset
`define CPU_PC_INIT 32'h0000_0000

// All-ones instruction stops the processor
`define CPU_HALT_WORD 32'hFFFF_FFFF

`endif

// ==== design/cpu_pkg.sv ====
// Shared datapath types, referenced by scoped name from the stages and the top level
`include "cpu_macros.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [`CPU_REG_W-1:0] regbits_t;

  // Primary opcodes of the supported subset
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0D,
    OP_LUI   = 6'h0F,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B,
    OP_HALT  = 6'h3F
  } opcode_t;

  // R-type function field
  typedef enum logic [5:0] {
    F_ADDU = 6'h21,
    F_SUBU = 6'h23,
    F_AND  = 6'h24,
    F_OR   = 6'h25,
    F_SLT  = 6'h2A
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } alu_op_t;

endpackage

// ==== design/fetch_stage.sv ====
// Fetch stage with PC, next-PC selection and fetch/decode register under hazard unit control
`include "cpu_macros.svh"

module fetch_stage #(
  parameter cpu_pkg::word_t PC_INIT = `CPU_PC_INIT
) (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           ihit,
  input  logic           flush,
  input  logic           freeze,
  input  logic           branch_taken,
  input  logic           jump_sel,
  input  cpu_pkg::word_t branch_addr,
  input  cpu_pkg::word_t jump_addr,
  input  cpu_pkg::word_t imemload,
  output logic           imemREN,
  output cpu_pkg::word_t imemaddr,
  output cpu_pkg::word_t fd_instr,
  output cpu_pkg::word_t fd_npc
);

  cpu_pkg::word_t pc;
  cpu_pkg::word_t pc_plus4;
  cpu_pkg::word_t next_pc;

  assign pc_plus4 = pc + 32'd4;

  // Jump beats branch as both resolve in decode
  always_comb begin
    if (jump_sel) begin
      next_pc = jump_addr;
    end else if (branch_taken) begin
      next_pc = branch_addr;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // Request stays up until the port answers
  assign imemREN = 1'b1;
  assign imemaddr = pc;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
      fd_instr <= '0;
      fd_npc <= '0;
    end else if (ihit && !freeze) begin
      pc <= next_pc;
      fd_npc <= pc_plus4;
      // squashed delay slot turns into an all-zero bubble
      fd_instr <= flush ? '0 : imemload;
    end
  end

endmodule

// ==== design/decode_stage.sv ====
// Decode stage with the register file, control decode, branch resolution and DE register
`include "cpu_macros.svh"

module decode_stage (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              flush,
  input  logic              freeze,
  input  cpu_pkg::word_t    fd_instr,
  input  cpu_pkg::word_t    fd_npc,
  input  cpu_pkg::word_t    wb_data,
  input  cpu_pkg::regbits_t wb_dest,
  input  logic              wb_wen,
  output logic              branch_taken,
  output cpu_pkg::word_t    branch_addr,
  output logic              jump_sel,
  output cpu_pkg::word_t    jump_addr,
  output cpu_pkg::word_t    de_rs_val,
  output cpu_pkg::word_t    de_rt_val,
  output cpu_pkg::word_t    de_imm,
  output cpu_pkg::regbits_t de_rs,
  output cpu_pkg::regbits_t de_rt,
  output cpu_pkg::regbits_t de_dest,
  output cpu_pkg::alu_op_t  de_alu_op,
  output logic              de_alu_src,
  output logic              de_dren,
  output logic              de_dwen,
  output logic              de_reg_wen,
  output logic              de_halt
);

  cpu_pkg::word_t    regs [`CPU_REG_COUNT];
  cpu_pkg::opcode_t  opcode;
  cpu_pkg::funct_t   funct;
  cpu_pkg::regbits_t rs, rt, rd, dest;
  cpu_pkg::word_t    rs_val, rt_val, imm;
  cpu_pkg::alu_op_t  alu_op;
  logic              alu_src, dren, dwen, reg_wen, halt_op, operands_eq;

  assign opcode = cpu_pkg::opcode_t'(fd_instr[31:26]);
  assign funct = cpu_pkg::funct_t'(fd_instr[5:0]);
  assign rs = fd_instr[25:21];
  assign rt = fd_instr[20:16];
  assign rd = fd_instr[15:11];

  // Register 0 of the register file is never written
  always_ff @(posedge CLK) begin
    if (wb_wen && wb_dest != '0) begin
      regs[wb_dest] <= wb_data;
    end
  end

  // Reads see a writeback landing in the same cycle
  assign rs_val = (rs == '0) ? '0 : (wb_wen && wb_dest == rs) ? wb_data : regs[rs];
  assign rt_val = (rt == '0) ? '0 : (wb_wen && wb_dest == rt) ? wb_data : regs[rt];

  always_comb begin
    alu_op = cpu_pkg::ALU_ADD;
    alu_src = 1'b0;
    dren = 1'b0;
    dwen = 1'b0;
    reg_wen = 1'b0;
    halt_op = 1'b0;
    dest = rt;
    imm = {{16{fd_instr[15]}}, fd_instr[15:0]};
    case (opcode)
      cpu_pkg::OP_RTYPE: begin
        dest = rd;
        reg_wen = 1'b1;
        case (funct)
          cpu_pkg::F_ADDU: alu_op = cpu_pkg::ALU_ADD;
          cpu_pkg::F_SUBU: alu_op = cpu_pkg::ALU_SUB;
          cpu_pkg::F_AND:  alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::F_OR:   alu_op = cpu_pkg::ALU_OR;
          cpu_pkg::F_SLT:  alu_op = cpu_pkg::ALU_SLT;
          // Unknown functions and bubbles write nothing
          default:         reg_wen = 1'b0;
        endcase
      end
      cpu_pkg::OP_ADDIU: begin
        alu_src = 1'b1;
        reg_wen = 1'b1;
      end
      cpu_pkg::OP_ORI: begin
        alu_op = cpu_pkg::ALU_OR;
        alu_src = 1'b1;
        reg_wen = 1'b1;
        imm = {16'h0000, fd_instr[15:0]};
      end
      cpu_pkg::OP_LUI: begin
        alu_op = cpu_pkg::ALU_LUI;
        alu_src = 1'b1;
        reg_wen = 1'b1;
      end
      cpu_pkg::OP_LW: begin
        alu_src = 1'b1;
        dren = 1'b1;
        reg_wen = 1'b1;
      end
      cpu_pkg::OP_SW: begin
        alu_src = 1'b1;
        dwen = 1'b1;
      end
      cpu_pkg::OP_HALT: halt_op = (fd_instr == `CPU_HALT_WORD);
      default: ;
    endcase
  end

  // Branch compare on register values with the target relative to PC+4
  assign operands_eq = (rs_val == rt_val);
  assign branch_taken = (opcode == cpu_pkg::OP_BEQ && operands_eq) ||
                        (opcode == cpu_pkg::OP_BNE && !operands_eq);
  assign branch_addr = fd_npc + {imm[29:0], 2'b00};

  // HALT spins on its own address so nothing behind it issues
  assign jump_sel = (opcode == cpu_pkg::OP_J) || halt_op;
  assign jump_addr = halt_op ? fd_npc - 32'd4 : {fd_npc[31:28], fd_instr[25:0], 2'b00};

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      de_dest <= '0;
      de_dren <= 1'b0;
      de_dwen <= 1'b0;
      de_reg_wen <= 1'b0;
      de_halt <= 1'b0;
    end else if (!freeze) begin
      // Destination is zero for anything that does not write
      de_dest <= (reg_wen && !flush) ? dest : '0;
      de_dren <= dren && !flush;
      de_dwen <= dwen && !flush;
      de_reg_wen <= reg_wen && !flush;
      de_halt <= halt_op && !flush;
    end
  end

  always_ff @(posedge CLK) begin
    if (!freeze) begin
      de_rs_val <= rs_val;
      de_rt_val <= rt_val;
      de_imm <= imm;
      de_rs <= rs;
      de_rt <= rt;
      de_alu_op <= alu_op;
      de_alu_src <= alu_src;
    end else begin
      // Pick up results that retire while this instruction is held
      if (wb_wen && wb_dest != '0 && wb_dest == de_rs) begin
        de_rs_val <= wb_data;
      end
      if (wb_wen && wb_dest != '0 && wb_dest == de_rt) begin
        de_rt_val <= wb_data;
      end
    end
  end

endmodule

// ==== design/execute_stage.sv ====
// Execute stage with operand forwarding, the ALU and the execute/memory register
module execute_stage (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              flush,
  input  logic              freeze,
  input  cpu_pkg::word_t    de_rs_val,
  input  cpu_pkg::word_t    de_rt_val,
  input  cpu_pkg::word_t    de_imm,
  input  cpu_pkg::regbits_t de_rs,
  input  cpu_pkg::regbits_t de_rt,
  input  cpu_pkg::regbits_t de_dest,
  input  cpu_pkg::alu_op_t  de_alu_op,
  input  logic              de_alu_src,
  input  logic              de_dren,
  input  logic              de_dwen,
  input  logic              de_reg_wen,
  input  logic              de_halt,
  input  cpu_pkg::word_t    wb_data,
  input  cpu_pkg::regbits_t wb_dest,
  input  logic              wb_wen,
  output cpu_pkg::word_t    em_result,
  output cpu_pkg::word_t    em_store,
  output cpu_pkg::regbits_t em_dest,
  output logic              em_dren,
  output logic              em_dwen,
  output logic              em_reg_wen,
  output logic              em_halt
);

  cpu_pkg::word_t rs_fwd, rt_fwd, operand_b, result;

  // Youngest producer wins so the memory stage beats writeback
  always_comb begin
    if (em_dest != '0 && em_dest == de_rs) begin
      rs_fwd = em_result;
    end else if (wb_wen && wb_dest != '0 && wb_dest == de_rs) begin
      rs_fwd = wb_data;
    end else begin
      rs_fwd = de_rs_val;
    end
    if (em_dest != '0 && em_dest == de_rt) begin
      rt_fwd = em_result;
    end else if (wb_wen && wb_dest != '0 && wb_dest == de_rt) begin
      rt_fwd = wb_data;
    end else begin
      rt_fwd = de_rt_val;
    end
  end

  assign operand_b = de_alu_src ? de_imm : rt_fwd;

  always_comb begin
    case (de_alu_op)
      cpu_pkg::ALU_SUB: result = rs_fwd - operand_b;
      cpu_pkg::ALU_AND: result = rs_fwd & operand_b;
      cpu_pkg::ALU_OR:  result = rs_fwd | operand_b;
      cpu_pkg::ALU_SLT: result = {31'd0, $signed(rs_fwd) < $signed(operand_b)};
      cpu_pkg::ALU_LUI: result = {operand_b[15:0], 16'h0000};
      default:          result = rs_fwd + operand_b;
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      em_dest <= '0;
      em_dren <= 1'b0;
      em_dwen <= 1'b0;
      em_reg_wen <= 1'b0;
      em_halt <= 1'b0;
    end else if (!freeze) begin
      em_dest <= flush ? '0 : de_dest;
      em_dren <= de_dren && !flush;
      em_dwen <= de_dwen && !flush;
      em_reg_wen <= de_reg_wen && !flush;
      em_halt <= de_halt && !flush;
    end
  end

  // Address or result plus store data for SW
  always_ff @(posedge CLK) begin
    if (!freeze) begin
      em_result <= result;
      em_store <= rt_fwd;
    end
  end

endmodule

// ==== design/memory_stage.sv ====
// Memory stage driving the data port, with the memory/writeback register and result selection
module memory_stage (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              flush,
  input  logic              freeze,
  input  cpu_pkg::word_t    em_result,
  input  cpu_pkg::word_t    em_store,
  input  cpu_pkg::regbits_t em_dest,
  input  logic              em_dren,
  input  logic              em_dwen,
  input  logic              em_reg_wen,
  input  logic              em_halt,
  input  cpu_pkg::word_t    dmemload,
  output logic              dmemREN,
  output logic              dmemWEN,
  output cpu_pkg::word_t    dmemaddr,
  output cpu_pkg::word_t    dmemstore,
  output cpu_pkg::word_t    wb_data,
  output cpu_pkg::regbits_t wb_dest,
  output logic              wb_wen,
  output logic              halt_seen
);

  cpu_pkg::word_t mem_result;
  logic           wb_halt;

  // Strobes stay up while the hazard unit holds this register
  assign dmemREN = em_dren;
  assign dmemWEN = em_dwen;
  assign dmemaddr = em_result;
  assign dmemstore = em_store;

  assign mem_result = em_dren ? dmemload : em_result;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wb_dest <= '0;
      wb_wen <= 1'b0;
      wb_halt <= 1'b0;
    end else if (!freeze) begin
      wb_dest <= flush ? '0 : em_dest;
      wb_wen <= em_reg_wen && !flush;
      wb_halt <= em_halt && !flush;
    end
  end

  always_ff @(posedge CLK) begin
    if (!freeze) begin
      wb_data <= mem_result;
    end
  end

  assign halt_seen = wb_halt;

endmodule

// ==== design/hazard_unit.sv ====
// Hazard unit for per-stage flush and freeze with fetch in bit 3 and memory in bit 0
module hazard_unit (
  input  logic              ihit,
  input  logic              dhit,
  input  logic              de_dren,
  input  cpu_pkg::regbits_t de_dest,
  input  cpu_pkg::regbits_t em_dest,
  input  logic              em_dren,
  input  logic              em_dwen,
  input  cpu_pkg::regbits_t fd_rs,
  input  cpu_pkg::regbits_t fd_rt,
  input  logic              fd_branch,
  input  logic              branch_taken,
  input  logic              jump_sel,
  output logic [3:0]        flush,
  output logic [3:0]        freeze
);

  logic de_match, em_match, stall, mem_access;

  // Destinations read as zero when nothing is written
  assign de_match = (de_dest != '0) && (de_dest == fd_rs || de_dest == fd_rt);
  assign em_match = (em_dest != '0) && (em_dest == fd_rs || em_dest == fd_rt);

  // Load-use or a branch whose operands are still in flight
  assign stall = (de_dren && de_match) || (fd_branch && (de_match || em_match));
  assign mem_access = em_dren || em_dwen;

  always_comb begin
    flush = 4'b0000;
    freeze = 4'b0000;
    if (mem_access && !dhit) begin
      freeze = 4'b1111;
    end else if (!ihit && mem_access) begin
      // Data access that ends while fetch waits retires and leaves a bubble behind
      freeze = 4'b1100;
      flush = 4'b0010;
    end else if (!ihit) begin
      freeze = 4'b1111;
    end else if (stall) begin
      freeze = 4'b1000;
      flush = 4'b0100;
    end else if (branch_taken || jump_sel) begin
      flush = 4'b1000;
    end
  end

endmodule

// ==== design/datapath.sv ====
// Top level of the five-stage MIPS datapath joining stages and hazard unit to the memory ports
`include "cpu_macros.svh"

module datapath #(
  parameter cpu_pkg::word_t PC_INIT = `CPU_PC_INIT
) (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           ihit,
  input  logic           dhit,
  input  cpu_pkg::word_t imemload,
  input  cpu_pkg::word_t dmemload,
  output logic           imemREN,
  output logic           dmemREN,
  output logic           dmemWEN,
  output cpu_pkg::word_t imemaddr,
  output cpu_pkg::word_t dmemaddr,
  output cpu_pkg::word_t dmemstore,
  output logic           halt
);

  // Fetch and decode
  cpu_pkg::word_t    fd_instr, fd_npc, branch_addr, jump_addr;
  logic              branch_taken, jump_sel;
  cpu_pkg::regbits_t fd_rs, fd_rt;
  logic              fd_branch;

  // Decode to execute
  cpu_pkg::word_t    de_rs_val, de_rt_val, de_imm;
  cpu_pkg::regbits_t de_rs, de_rt, de_dest;
  cpu_pkg::alu_op_t  de_alu_op;
  logic              de_alu_src, de_dren, de_dwen, de_reg_wen, de_halt;

  // Execute to memory and writeback
  cpu_pkg::word_t    em_result, em_store, wb_data;
  cpu_pkg::regbits_t em_dest, wb_dest;
  logic              em_dren, em_dwen, em_reg_wen, em_halt, wb_wen, halt_seen;

  logic [3:0] flush, freeze;
  logic       fetch_freeze;

  assign fd_rs = fd_instr[25:21];
  assign fd_rt = fd_instr[20:16];
  assign fd_branch = (fd_instr[31:26] == cpu_pkg::OP_BEQ) ||
                     (fd_instr[31:26] == cpu_pkg::OP_BNE);

  // No new fetches once HALT has retired
  assign fetch_freeze = freeze[3] || halt_seen || halt;

  fetch_stage #(.PC_INIT(PC_INIT)) fetch_i (.flush(flush[3]), .freeze(fetch_freeze), .*);
  decode_stage  decode_i  (.flush(flush[2]), .freeze(freeze[2]), .*);
  execute_stage execute_i (.flush(flush[1]), .freeze(freeze[1]), .*);
  memory_stage  memory_i  (.flush(flush[0]), .freeze(freeze[0]), .*);
  hazard_unit   hazard_i  (.*);

  // Sticky until reset
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (halt_seen) begin
      halt <= 1'b1;
    end
  end

endmodule

// ==== bench/datapath_tb.sv ====
// Self-checking testbench that runs the datapath program from the stimulus file and checks its stores
module datapath_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam cpu_pkg::word_t RESET_PC = 32'h0000_0000;
  localparam cpu_pkg::word_t HALT_WORD = 32'hFFFF_FFFF;
  localparam int HALT_TIMEOUT = 3000;
  localparam int QUIET_CYCLES = 20;

  logic           CLK = 1'b0;
  logic           nRST;
  logic           ihit;
  logic           dhit;
  cpu_pkg::word_t imemload;
  cpu_pkg::word_t dmemload;
  logic           imemREN;
  logic           dmemREN;
  logic           dmemWEN;
  cpu_pkg::word_t imemaddr;
  cpu_pkg::word_t dmemaddr;
  cpu_pkg::word_t dmemstore;
  logic           halt;

  // Two 256-word memory models indexed by address bits 9:2
  cpu_pkg::word_t imem [0:255];
  cpu_pkg::word_t dmem [0:255];
  cpu_pkg::word_t exp_addr [$];
  cpu_pkg::word_t exp_data [$];
  int             store_count;
  int             i_wait;
  int             d_wait;
  logic           i_busy;
  logic           d_busy;

  datapath datapath_i (.*);

  always #5 CLK = ~CLK;

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input cpu_pkg::word_t actual, input cpu_pkg::word_t expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      stop_run();
    end
  endtask

  // Background data that differs at every address
  function automatic cpu_pkg::word_t fill_word(input cpu_pkg::word_t addr);
    return addr ^ 32'h5A5A_A5A5;
  endfunction

  function automatic cpu_pkg::word_t read_imem(input cpu_pkg::word_t addr);
    if (addr[31:10] != '0) begin
      return HALT_WORD;
    end
    return imem[addr[9:2]];
  endfunction

  function automatic cpu_pkg::word_t read_dmem(input cpu_pkg::word_t addr);
    if (addr[31:10] != '0) begin
      return fill_word(addr);
    end
    return dmem[addr[9:2]];
  endfunction

  task automatic load_stimulus();
    int             fd;
    int             n;
    string          line;
    logic [7:0]     tag;
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    // Unused program slots halt
    for (int i = 0; i < 256; i++) begin
      imem[i] = HALT_WORD;
      dmem[i] = fill_word(cpu_pkg::word_t'(i) << 2);
    end
    fd = $fopen("bench/datapath_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file bench/datapath_stimulus.txt");
      stop_run();
    end
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%c %h %h", tag, a, b);
      if (n == 3) begin
        case (tag)
          "I": imem[a[9:2]] = b;
          "D": dmem[a[9:2]] = b;
          "E": begin
            exp_addr.push_back(a);
            exp_data.push_back(b);
          end
          default: ;
        endcase
      end
    end
    $fclose(fd);
  endtask

  // Compare each committed store with the next expected one
  task automatic record_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
    if (store_count >= exp_addr.size()) begin
      $display("Unexpected store of %h to address %h after the expected sequence", data, addr);
      stop_run();
    end
    check_value(addr, exp_addr[store_count], $sformatf("address of store %0d", store_count));
    check_value(data, exp_data[store_count], $sformatf("data of store %0d", store_count));
    if (addr[31:10] == '0) begin
      dmem[addr[9:2]] = data;
    end
    store_count++;
  endtask

  // Instruction port gives one strobe per request after 0 to 3 wait cycles
  always @(posedge CLK) begin
    #1;
    ihit = 1'b0;
    if (imemREN) begin
      if (!i_busy) begin
        i_wait = $urandom % 4;
        i_busy = 1'b1;
      end
      if (i_wait == 0) begin
        ihit = 1'b1;
        imemload = read_imem(imemaddr);
        i_busy = 1'b0;
      end else begin
        i_wait--;
      end
    end
  end

  // Data port commits a store when its strobe is given
  always @(posedge CLK) begin
    #1;
    dhit = 1'b0;
    if (dmemREN || dmemWEN) begin
      if (!d_busy) begin
        d_wait = $urandom % 4;
        d_busy = 1'b1;
      end
      if (d_wait == 0) begin
        dhit = 1'b1;
        d_busy = 1'b0;
        if (dmemWEN) begin
          record_store(dmemaddr, dmemstore);
        end else begin
          dmemload = read_dmem(dmemaddr);
        end
      end else begin
        d_wait--;
      end
    end
  end

  initial begin
    int cycles;
    void'($urandom(19000));
    nRST = 1'b0;
    ihit = 1'b0;
    dhit = 1'b0;
    imemload = '0;
    dmemload = '0;
    i_busy = 1'b0;
    d_busy = 1'b0;
    i_wait = 0;
    d_wait = 0;
    store_count = 0;
    load_stimulus();
    repeat (2) @(posedge CLK);
    #1;
    nRST = 1'b1;
    #1;
    check_value(imemaddr, RESET_PC, "imemaddr after reset");
    check_value(cpu_pkg::word_t'(imemREN), 32'd1, "imemREN after reset");
    check_value(cpu_pkg::word_t'(dmemREN), '0, "dmemREN after reset");
    check_value(cpu_pkg::word_t'(dmemWEN), '0, "dmemWEN after reset");
    check_value(cpu_pkg::word_t'(halt), '0, "halt after reset");

    cycles = 0;
    while (!halt && cycles < HALT_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    if (!halt) begin
      $display("Timed out after %0d cycles waiting for halt", HALT_TIMEOUT);
      stop_run();
    end
    check_value(store_count, exp_addr.size(), "store count when halt rose");

    // Data port stays quiet once halted
    for (cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
      @(negedge CLK);
      if (dmemWEN) begin
        $display("A store was issued at %0t ns after halt had risen", $time);
        stop_run();
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/cpu_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/hazard_unit.sv
design/datapath.sv
bench/datapath_tb.sv

// ==== bench/datapath_stimulus.txt ====
# Columns: tag, address, word, all hexadecimal
# I = instruction image, E = expected store in program order, D = initial data memory
I 00000000 3C011234
I 00000004 34215678
I 00000008 24020200
I 0000000C 2403FFFD
I 00000010 00232021
I 00000014 AC440000
I 00000018 00812823
I 0000001C 00A0302A
I 00000020 00243824
I 00000024 00E64025
I 00000028 AC450004
I 0000002C AC480008
I 00000030 8C490040
I 00000034 252A0025
I 00000038 AC4A000C
I 0000003C 114A0002
I 00000040 AC410010
I 00000044 AC410014
I 00000048 14C60003
I 0000004C AC460010
I 00000050 08000016
I 00000054 AC410014
I 00000058 AC470014
I 0000005C FFFFFFFF
D 00000240 00001000
E 00000200 12345675
E 00000204 FFFFFFFD
E 00000208 12345671
E 0000020C 00001025
E 00000210 00000001
E 00000214 12345670
